//--- compile.f
+incdir+rtl
rtl/modbusPkg.sv
rtl/modbusCrc16.sv
rtl/requestParser.sv
rtl/registerBuffer.sv
rtl/responseSequencer.sv
rtl/modbusWishboneBridge.sv
test/tb_modbusWishboneBridge.sv

//--- rtl/modbusCrc16.sv
module modbusCrc16 (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        enable,
    input  logic [7:0]  data,
    output logic [15:0] crc
);

    // one byte through the reflected polynomial, lsb first
    function automatic logic [15:0] foldByte(input logic [15:0] crcIn, input logic [7:0] byteIn);
        logic [15:0] acc;
        acc = crcIn ^ {8'h00, byteIn};
        for (int i = 0; i < 8; i++) begin
            if (acc[0]) begin
                acc = (acc >> 1) ^ 16'hA001;
            end else begin
                acc = acc >> 1;
            end
        end
        return acc;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= 16'hFFFF;
        end else if (enable) begin
            crc <= foldByte(crc, data);
        end
    end

endmodule

//--- rtl/modbusPkg.sv
`include "modbus_defines.svh"

package modbusPkg;

    typedef enum logic [7:0] {
        READ_HOLDING   = 8'h03,
        READ_INPUT     = 8'h04,
        WRITE_MULTIPLE = 8'h10
    } functionCode_t;

    typedef enum logic [7:0] {
        NONE             = 8'h00,
        ILLEGAL_FUNCTION = 8'h01,
        ILLEGAL_ADDRESS  = 8'h02,
        ILLEGAL_VALUE    = 8'h03
    } exceptionCode_t;

    typedef enum logic [4:0] {
        RX_STATION, RX_WAIT, RX_FUNCTION, RX_ADDR_HI, RX_ADDR_LO, RX_QTY_HI, RX_QTY_LO,
        RX_BYTE_COUNT, RX_DATA_HI, RX_DATA_LO, RX_CRC_LO, RX_CRC_HI
    } rxState_t;

    typedef enum logic [4:0] {
        TX_IDLE, TX_WB_WRITE, TX_STATION, TX_FUNCTION, TX_EXCEPTION, TX_BYTE_COUNT,
        TX_WB_READ, TX_DATA_HI, TX_DATA_LO, TX_ADDR_HI, TX_ADDR_LO, TX_QTY_HI, TX_QTY_LO,
        TX_CRC_LO, TX_CRC_HI
    } txState_t;

    typedef struct packed {
        logic [7:0] data;
        logic       parityError;
    } uartByte_t;

    typedef struct packed {
        functionCode_t  funcCode; // raw code, may be unsupported
        exceptionCode_t exception;
        logic [15:0]    startAddress;
        logic [15:0]    quantity;
    } request_t;

    typedef struct packed {
        logic [`WB_ADDR_WIDTH-1:0] adr;
        logic [`WB_DATA_WIDTH-1:0] dat;
        logic                      cyc;
        logic                      stb;
        logic                      we;
    } wbMaster_t;

endpackage

//--- rtl/modbusWishboneBridge.sv
`include "modbus_defines.svh"

module modbusWishboneBridge (
    input  logic                      clk,
    input  logic                      rst,
    input  modbusPkg::uartByte_t      rxByte,
    input  logic                      rxValid,
    input  logic                      silence,
    output logic [7:0]                txData,
    output logic                      txReq,
    input  logic                      txAck,
    output modbusPkg::wbMaster_t      wbOut,
    input  logic [`WB_DATA_WIDTH-1:0] wbReadData,
    input  logic                      wbAck
);

    modbusPkg::request_t          request;
    logic                         requestValid;
    logic                         responseDone;
    logic                         bufClear;
    logic                         bufWrite;
    logic [`WB_DATA_WIDTH-1:0]    bufWriteData;
    logic [`BUFFER_PTR_WIDTH-1:0] bufWriteCount;
    logic                         bufRewind;
    logic                         bufNext;
    logic [`WB_DATA_WIDTH-1:0]    bufReadData;

    requestParser u_requestParser (
        .clk           (clk),
        .rst           (rst),
        .rxByte        (rxByte),
        .rxValid       (rxValid),
        .silence       (silence),
        .request       (request),
        .requestValid  (requestValid),
        .responseDone  (responseDone),
        .bufClear      (bufClear),
        .bufWrite      (bufWrite),
        .bufWriteData  (bufWriteData),
        .bufWriteCount (bufWriteCount)
    );

    registerBuffer u_registerBuffer (
        .clk        (clk),
        .rst        (rst),
        .clear      (bufClear),
        .write      (bufWrite),
        .writeData  (bufWriteData),
        .writeCount (bufWriteCount),
        .rewind     (bufRewind),
        .next       (bufNext),
        .readData   (bufReadData)
    );

    responseSequencer u_responseSequencer (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .requestValid (requestValid),
        .responseDone (responseDone),
        .wbOut        (wbOut),
        .wbReadData   (wbReadData),
        .wbAck        (wbAck),
        .bufRewind    (bufRewind),
        .bufNext      (bufNext),
        .bufReadData  (bufReadData),
        .txData       (txData),
        .txReq        (txReq),
        .txAck        (txAck)
    );

endmodule

//--- rtl/modbus_defines.svh
`ifndef MODBUS_DEFINES_SVH
`define MODBUS_DEFINES_SVH

// this slave on the RTU line
`define STATION_ADDRESS 8'h37

// wishbone geometry
`define WB_ADDR_WIDTH 24
`define WB_DATA_WIDTH 16

// register windows on the bus
`define OFFSET_HOLDING_REGS 24'hA00000
`define OFFSET_INPUT_REGS 24'hA10000

// quantity limits per function
`define MAX_READ_QUANTITY 16'd125
`define MAX_WRITE_QUANTITY 16'd123

// write staging buffer
`define BUFFER_DEPTH 128
`define BUFFER_PTR_WIDTH 7

`endif

//--- rtl/registerBuffer.sv
`include "modbus_defines.svh"

module registerBuffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         clear,
    input  logic                         write,
    input  logic [`WB_DATA_WIDTH-1:0]    writeData,
    output logic [`BUFFER_PTR_WIDTH-1:0] writeCount,
    input  logic                         rewind,
    input  logic                         next,
    output logic [`WB_DATA_WIDTH-1:0]    readData
);

    logic [`WB_DATA_WIDTH-1:0]    mem [`BUFFER_DEPTH];
    logic [`BUFFER_PTR_WIDTH-1:0] readPtr;

    always_ff @(posedge clk) begin
        if (write) begin
            mem[writeCount] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            writeCount <= '0;
        end else if (write) begin
            writeCount <= writeCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || rewind) begin
            readPtr <= '0;
        end else if (next) begin
            readPtr <= readPtr + 1'b1;
        end
    end

    assign readData = mem[readPtr]; // follows pointer directly

endmodule

//--- rtl/requestParser.sv
`include "modbus_defines.svh"

module requestParser (
    input  logic                         clk,
    input  logic                         rst,
    input  modbusPkg::uartByte_t         rxByte,
    input  logic                         rxValid,
    input  logic                         silence,
    output modbusPkg::request_t          request,
    output logic                         requestValid,
    input  logic                         responseDone,
    output logic                         bufClear,
    output logic                         bufWrite,
    output logic [15:0]                  bufWriteData,
    input  logic [`BUFFER_PTR_WIDTH-1:0] bufWriteCount
);

    modbusPkg::rxState_t state;
    logic [7:0]          dataHi;
    logic                accept;
    logic                goodByte;
    logic [15:0]         quantityNow;
    logic [16:0]         endAddress;
    logic                readQtyBad;
    logic                writeQtyBad;
    logic                countBad;
    logic                addressBad;

    assign accept   = rxValid && !silence && !requestValid; // frozen while answering
    assign goodByte = accept && !rxByte.parityError;

    // low quantity byte is still on the bus in RX_QTY_LO
    assign quantityNow = (state == modbusPkg::RX_QTY_LO) ?
                         {request.quantity[15:8], rxByte.data} : request.quantity;
    assign endAddress  = {1'b0, request.startAddress} + {1'b0, quantityNow};
    assign addressBad  = endAddress > 17'h0FFFF;
    assign readQtyBad  = quantityNow == 16'd0 || quantityNow > `MAX_READ_QUANTITY;
    assign writeQtyBad = quantityNow == 16'd0 || quantityNow > `MAX_WRITE_QUANTITY;
    assign countBad    = rxByte.data != {quantityNow[6:0], 1'b0};

    assign bufClear     = goodByte && state == modbusPkg::RX_BYTE_COUNT;
    assign bufWrite     = goodByte && state == modbusPkg::RX_DATA_LO;
    assign bufWriteData = {dataHi, rxByte.data};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= modbusPkg::RX_STATION;
            requestValid <= 1'b0;
        end else begin
            if (responseDone) begin
                requestValid <= 1'b0;
            end
            if (silence) begin
                state <= modbusPkg::RX_STATION; // frame gap
            end else if (accept && rxByte.parityError) begin
                state <= modbusPkg::RX_WAIT;
            end else if (accept) begin
                case (state)
                    modbusPkg::RX_STATION: begin
                        request.exception <= modbusPkg::NONE;
                        if (rxByte.data == `STATION_ADDRESS) begin
                            state <= modbusPkg::RX_FUNCTION;
                        end else begin
                            state <= modbusPkg::RX_WAIT; // not for us
                        end
                    end
                    modbusPkg::RX_FUNCTION: begin
                        request.funcCode <= modbusPkg::functionCode_t'(rxByte.data);
                        if (rxByte.data == modbusPkg::READ_HOLDING ||
                            rxByte.data == modbusPkg::READ_INPUT ||
                            rxByte.data == modbusPkg::WRITE_MULTIPLE) begin
                            state <= modbusPkg::RX_ADDR_HI;
                        end else begin
                            request.exception <= modbusPkg::ILLEGAL_FUNCTION;
                            requestValid      <= 1'b1;
                            state             <= modbusPkg::RX_WAIT;
                        end
                    end
                    modbusPkg::RX_ADDR_HI: begin
                        request.startAddress[15:8] <= rxByte.data;
                        state                      <= modbusPkg::RX_ADDR_LO;
                    end
                    modbusPkg::RX_ADDR_LO: begin
                        request.startAddress[7:0] <= rxByte.data;
                        state                     <= modbusPkg::RX_QTY_HI;
                    end
                    modbusPkg::RX_QTY_HI: begin
                        request.quantity[15:8] <= rxByte.data;
                        state                  <= modbusPkg::RX_QTY_LO;
                    end
                    modbusPkg::RX_QTY_LO: begin
                        request.quantity[7:0] <= rxByte.data;
                        if (request.funcCode == modbusPkg::WRITE_MULTIPLE) begin
                            state <= modbusPkg::RX_BYTE_COUNT; // checked with byte count
                        end else if (readQtyBad || addressBad) begin
                            request.exception <= readQtyBad ? modbusPkg::ILLEGAL_VALUE :
                                                              modbusPkg::ILLEGAL_ADDRESS;
                            requestValid      <= 1'b1;
                            state             <= modbusPkg::RX_WAIT;
                        end else begin
                            state <= modbusPkg::RX_CRC_LO;
                        end
                    end
                    modbusPkg::RX_BYTE_COUNT: begin
                        if (writeQtyBad || countBad || addressBad) begin
                            request.exception <= (writeQtyBad || countBad) ?
                                                 modbusPkg::ILLEGAL_VALUE :
                                                 modbusPkg::ILLEGAL_ADDRESS;
                            requestValid      <= 1'b1;
                            state             <= modbusPkg::RX_WAIT;
                        end else begin
                            state <= modbusPkg::RX_DATA_HI;
                        end
                    end
                    modbusPkg::RX_DATA_HI: begin
                        dataHi <= rxByte.data;
                        state  <= modbusPkg::RX_DATA_LO;
                    end
                    modbusPkg::RX_DATA_LO: begin
                        // count is taken before this word lands
                        if (bufWriteCount + 7'd1 == request.quantity[6:0]) begin
                            state <= modbusPkg::RX_CRC_LO;
                        end else begin
                            state <= modbusPkg::RX_DATA_HI;
                        end
                    end
                    modbusPkg::RX_CRC_LO: begin
                        state <= modbusPkg::RX_CRC_HI; // crc not checked
                    end
                    modbusPkg::RX_CRC_HI: begin
                        requestValid <= 1'b1;
                        state        <= modbusPkg::RX_WAIT;
                    end
                    default: begin
                        state <= modbusPkg::RX_WAIT; // only silence leaves
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/responseSequencer.sv
`include "modbus_defines.svh"

module responseSequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  modbusPkg::request_t       request,
    input  logic                      requestValid,
    output logic                      responseDone,
    output modbusPkg::wbMaster_t      wbOut,
    input  logic [`WB_DATA_WIDTH-1:0] wbReadData,
    input  logic                      wbAck,
    output logic                      bufRewind,
    output logic                      bufNext,
    input  logic [`WB_DATA_WIDTH-1:0] bufReadData,
    output logic [7:0]                txData,
    output logic                      txReq,
    input  logic                      txAck
);

    modbusPkg::txState_t          state;
    logic [`WB_ADDR_WIDTH-1:0]    wbAddr;
    logic [`WB_ADDR_WIDTH-1:0]    baseAddr;
    logic [`BUFFER_PTR_WIDTH-1:0] wordIndex;
    logic [`WB_DATA_WIDTH-1:0]    readWord;
    logic [15:0]                  crc;
    logic                         byteDone;
    logic                         busActive;
    logic                         isWrite;
    logic                         isError;
    logic                         lastWord;
    logic                         crcEnable;

    assign isWrite  = request.funcCode == modbusPkg::WRITE_MULTIPLE;
    assign isError  = request.exception != modbusPkg::NONE;
    assign lastWord = wordIndex == request.quantity[6:0] - 7'd1;
    assign baseAddr = (request.funcCode == modbusPkg::READ_INPUT) ?
                      `OFFSET_INPUT_REGS : `OFFSET_HOLDING_REGS;

    assign busActive = state == modbusPkg::TX_WB_WRITE || state == modbusPkg::TX_WB_READ;
    assign wbOut.adr = wbAddr;
    assign wbOut.dat = bufReadData;
    assign wbOut.cyc = busActive;
    assign wbOut.stb = busActive;
    assign wbOut.we  = state == modbusPkg::TX_WB_WRITE;

    assign bufRewind = state == modbusPkg::TX_IDLE;
    assign bufNext   = state == modbusPkg::TX_WB_WRITE && wbAck;

    assign txReq        = !busActive && state != modbusPkg::TX_IDLE;
    assign byteDone     = txReq && txAck;
    assign responseDone = state == modbusPkg::TX_CRC_HI && byteDone;
    assign crcEnable    = byteDone && state != modbusPkg::TX_CRC_LO &&
                          state != modbusPkg::TX_CRC_HI;

    always_comb begin
        case (state)
            modbusPkg::TX_FUNCTION:   txData = isError ? {1'b1, request.funcCode[6:0]} :
                                                         request.funcCode;
            modbusPkg::TX_EXCEPTION:  txData = request.exception;
            modbusPkg::TX_BYTE_COUNT: txData = {request.quantity[6:0], 1'b0};
            modbusPkg::TX_DATA_HI:    txData = readWord[15:8];
            modbusPkg::TX_DATA_LO:    txData = readWord[7:0];
            modbusPkg::TX_ADDR_HI:    txData = request.startAddress[15:8];
            modbusPkg::TX_ADDR_LO:    txData = request.startAddress[7:0];
            modbusPkg::TX_QTY_HI:     txData = request.quantity[15:8];
            modbusPkg::TX_QTY_LO:     txData = request.quantity[7:0];
            modbusPkg::TX_CRC_LO:     txData = crc[7:0]; // low byte first
            modbusPkg::TX_CRC_HI:     txData = crc[15:8];
            default:                  txData = `STATION_ADDRESS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= modbusPkg::TX_IDLE;
        end else begin
            case (state)
                modbusPkg::TX_IDLE: begin
                    wbAddr    <= baseAddr + {{(`WB_ADDR_WIDTH-16){1'b0}}, request.startAddress};
                    wordIndex <= '0;
                    if (requestValid) begin
                        state <= (isWrite && !isError) ? modbusPkg::TX_WB_WRITE :
                                                         modbusPkg::TX_STATION;
                    end
                end
                modbusPkg::TX_WB_WRITE: begin
                    if (wbAck) begin
                        wbAddr    <= wbAddr + 1'b1;
                        wordIndex <= wordIndex + 1'b1;
                        if (lastWord) begin
                            state <= modbusPkg::TX_STATION; // buffer drained
                        end
                    end
                end
                modbusPkg::TX_STATION: if (byteDone) state <= modbusPkg::TX_FUNCTION;
                modbusPkg::TX_FUNCTION: begin
                    if (byteDone) begin
                        if (isError) begin
                            state <= modbusPkg::TX_EXCEPTION;
                        end else if (isWrite) begin
                            state <= modbusPkg::TX_ADDR_HI;
                        end else begin
                            state <= modbusPkg::TX_BYTE_COUNT;
                        end
                    end
                end
                modbusPkg::TX_EXCEPTION:  if (byteDone) state <= modbusPkg::TX_CRC_LO;
                modbusPkg::TX_BYTE_COUNT: if (byteDone) state <= modbusPkg::TX_WB_READ;
                modbusPkg::TX_WB_READ: begin
                    if (wbAck) begin
                        readWord <= wbReadData;
                        state    <= modbusPkg::TX_DATA_HI;
                    end
                end
                modbusPkg::TX_DATA_HI: if (byteDone) state <= modbusPkg::TX_DATA_LO;
                modbusPkg::TX_DATA_LO: begin
                    if (byteDone) begin
                        wbAddr    <= wbAddr + 1'b1;
                        wordIndex <= wordIndex + 1'b1;
                        state     <= lastWord ? modbusPkg::TX_CRC_LO : modbusPkg::TX_WB_READ;
                    end
                end
                modbusPkg::TX_ADDR_HI: if (byteDone) state <= modbusPkg::TX_ADDR_LO;
                modbusPkg::TX_ADDR_LO: if (byteDone) state <= modbusPkg::TX_QTY_HI;
                modbusPkg::TX_QTY_HI:  if (byteDone) state <= modbusPkg::TX_QTY_LO;
                modbusPkg::TX_QTY_LO:  if (byteDone) state <= modbusPkg::TX_CRC_LO;
                modbusPkg::TX_CRC_LO:  if (byteDone) state <= modbusPkg::TX_CRC_HI;
                modbusPkg::TX_CRC_HI:  if (byteDone) state <= modbusPkg::TX_IDLE;
                default:               state <= modbusPkg::TX_IDLE;
            endcase
        end
    end

    modbusCrc16 u_modbusCrc16 (
        .clk    (clk),
        .rst    (rst),
        .clear  (state == modbusPkg::TX_IDLE),
        .enable (crcEnable),
        .data   (txData),
        .crc    (crc)
    );

endmodule

//--- run.sh
#!/bin/sh
# builds and runs the testbench; exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal \
    --top-module tb_modbusWishboneBridge \
    -f compile.f \
    -o tbSim
./obj_dir/tbSim

//--- test/tb_modbusWishboneBridge.sv
`include "modbus_defines.svh"

module tb_modbusWishboneBridge;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_CYCLES = 400; // worst case per table entry
    localparam int MAX_FRAMES   = 16;
    localparam int MAX_BYTES    = 20;

    logic                      clk;
    logic                      rst;
    modbusPkg::uartByte_t      rxByte;
    logic                      rxValid;
    logic                      silence;
    logic [7:0]                txData;
    logic                      txReq;
    logic                      txAck;
    modbusPkg::wbMaster_t      wbOut;
    logic [`WB_DATA_WIDTH-1:0] wbReadData;
    logic                      wbAck;

    logic [8*MAX_BYTES-1:0] tablePayload [MAX_FRAMES]; // right aligned, no crc
    int                     tableLength [MAX_FRAMES];
    bit                     tableRespond [MAX_FRAMES];
    int                     tableParity [MAX_FRAMES];  // byte index with parity error, or -1
    int                     numFrames;
    bit                     tableReady;

    logic [7:0]  frame [$];
    logic [7:0]  expected [$];
    logic [7:0]  received [$];
    logic [15:0] busMem [logic [23:0]]; // wishbone slave storage
    logic [15:0] refMem [logic [23:0]]; // expected register contents
    logic [31:0] lfsrState;
    bit          txReqSeen;

    modbusWishboneBridge u_modbusWishboneBridge (
        .clk        (clk),
        .rst        (rst),
        .rxByte     (rxByte),
        .rxValid    (rxValid),
        .silence    (silence),
        .txData     (txData),
        .txReq      (txReq),
        .txAck      (txAck),
        .wbOut      (wbOut),
        .wbReadData (wbReadData),
        .wbAck      (wbAck)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    function automatic logic [15:0] patternWord(input logic [23:0] a);
        return {a[7:0] ^ a[23:16], a[15:8] ^ ~a[7:0]};
    endfunction

    function automatic logic [15:0] busRead(input logic [23:0] a);
        return busMem.exists(a) ? busMem[a] : patternWord(a);
    endfunction

    function automatic logic [15:0] refRead(input logic [23:0] a);
        return refMem.exists(a) ? refMem[a] : patternWord(a);
    endfunction

    function automatic logic [15:0] crcStep(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) begin
                c = (c >> 1) ^ 16'hA001;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] want);
        if (actual !== want) begin
            $display("[FAIL] time %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, want);
            $display("Test FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic drawDelay(output int cycles);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits[i]   = lfsrState[0];
        end
        cycles = bits;
    endtask

    task automatic addFrame(input logic [8*MAX_BYTES-1:0] payload, input int length,
                            input bit respond, input int parityAt);
        tablePayload[numFrames] = payload;
        tableLength[numFrames]  = length;
        tableRespond[numFrames] = respond;
        tableParity[numFrames]  = parityAt;
        numFrames++;
    endtask

    task automatic pulseSilence();
        @(posedge clk);
        #1;
        silence = 1'b1;
        @(posedge clk);
        #1;
        silence = 1'b0;
    endtask

    task automatic sendFrame(input int parityAt);
        foreach (frame[i]) begin
            @(posedge clk);
            #1;
            rxByte.data        = frame[i];
            rxByte.parityError = (i == parityAt);
            rxValid            = 1'b1;
        end
        @(posedge clk);
        #1;
        rxValid            = 1'b0;
        rxByte.parityError = 1'b0;
    endtask

    // expected reply from the request bytes, before the request crc is added
    task automatic buildExpected(input int idx);
        logic [7:0]  func;
        logic [15:0] start;
        logic [15:0] qty;
        logic [16:0] endAddr;
        logic [23:0] base;
        logic [15:0] word;
        logic [15:0] crc;
        bit          qtyBad;
        expected.delete();
        if (!tableRespond[idx]) return;
        func    = frame[1];
        start   = {frame[2], frame[3]};
        qty     = {frame[4], frame[5]};
        endAddr = {1'b0, start} + {1'b0, qty};
        base    = (func == 8'h04) ? `OFFSET_INPUT_REGS : `OFFSET_HOLDING_REGS;
        if (func == 8'h10) begin
            qtyBad = qty == 0 || qty > `MAX_WRITE_QUANTITY || {8'h00, frame[6]} != (qty << 1);
        end else begin
            qtyBad = qty == 0 || qty > `MAX_READ_QUANTITY;
        end
        expected.push_back(`STATION_ADDRESS);
        if (func != 8'h03 && func != 8'h04 && func != 8'h10) begin
            expected.push_back(func | 8'h80);
            expected.push_back(8'h01);
        end else if (qtyBad) begin
            expected.push_back(func | 8'h80);
            expected.push_back(8'h03);
        end else if (endAddr > 17'h0FFFF) begin
            expected.push_back(func | 8'h80);
            expected.push_back(8'h02);
        end else if (func == 8'h10) begin
            for (int i = 0; i < qty; i++) begin
                refMem[24'(base + start + i)] = {frame[7 + 2*i], frame[8 + 2*i]};
            end
            expected.push_back(func);
            expected.push_back(start[15:8]);
            expected.push_back(start[7:0]);
            expected.push_back(qty[15:8]);
            expected.push_back(qty[7:0]);
        end else begin
            expected.push_back(func);
            expected.push_back(8'(qty << 1));
            for (int i = 0; i < qty; i++) begin
                word = refRead(24'(base + start + i));
                expected.push_back(word[15:8]); // high byte first
                expected.push_back(word[7:0]);
            end
        end
        crc = 16'hFFFF;
        foreach (expected[i]) crc = crcStep(crc, expected[i]);
        expected.push_back(crc[7:0]);
        expected.push_back(crc[15:8]);
    endtask

    task automatic runFrame(input int idx);
        logic [15:0] crc;
        frame.delete();
        for (int i = 0; i < tableLength[idx]; i++) begin
            frame.push_back(tablePayload[idx][8*(tableLength[idx]-1-i) +: 8]);
        end
        buildExpected(idx);
        crc = 16'hFFFF;
        foreach (frame[i]) crc = crcStep(crc, frame[i]);
        frame.push_back(crc[7:0]);
        frame.push_back(crc[15:8]);
        received.delete();
        txReqSeen = 1'b0;
        pulseSilence();
        sendFrame(tableParity[idx]);
        if (tableRespond[idx]) begin
            while (received.size() < expected.size()) @(posedge clk);
            repeat (8) @(posedge clk); // any extra byte would show up here
            checkValue("response length", received.size(), expected.size());
            foreach (expected[i]) checkValue("txData", received[i], expected[i]);
            foreach (refMem[a]) checkValue("wishbone memory", busRead(a), refMem[a]);
        end else begin
            repeat (20) @(posedge clk);
            checkValue("txReq", txReqSeen, 1'b0);
        end
    endtask

    // wishbone slave with 0 to 3 wait cycles
    initial begin : wishboneModel
        int delay;
        wbAck      = 1'b0;
        wbReadData = '0;
        forever begin
            @(posedge clk);
            #1;
            wbAck = 1'b0;
            if (wbOut.cyc === 1'b1 && wbOut.stb === 1'b1) begin
                drawDelay(delay);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                if (wbOut.we) begin
                    busMem[wbOut.adr] = wbOut.dat;
                end else begin
                    wbReadData = busRead(wbOut.adr);
                end
                wbAck = 1'b1;
            end
        end
    end

    // response FIFO sink
    initial begin : fifoSink
        int delay;
        txAck = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            txAck = 1'b0;
            if (txReq === 1'b1) begin
                txReqSeen = 1'b1;
                drawDelay(delay);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                received.push_back(txData);
                txAck = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (tableReady);
        #(CLK_PERIOD * (RESET_CYCLES + numFrames * FRAME_CYCLES));
        $display("Timeout: the response to a request never completed");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        rxByte    = '0;
        rxValid   = 1'b0;
        silence   = 1'b0;
        lfsrState = 32'hfbd457fb;
        numFrames = 0;
        addFrame({8'h37, 8'h03, 16'h0010, 16'h0003}, 6, 1, -1);
        addFrame({8'h37, 8'h04, 16'h0020, 16'h0002}, 6, 1, -1); // input window
        addFrame({8'h37, 8'h10, 16'h0010, 16'h0004, 8'h08, 64'h1234_ABCD_0F0F_8001}, 15, 1, -1);
        addFrame({8'h37, 8'h03, 16'h0010, 16'h0004}, 6, 1, -1); // reads the write back
        addFrame({8'h37, 8'h05, 16'h0000, 16'h0001}, 6, 1, -1);
        addFrame({8'h37, 8'h03, 16'h0000, 16'h0000}, 6, 1, -1);
        addFrame({8'h37, 8'h03, 16'h0000, 16'd126}, 6, 1, -1);
        addFrame({8'h37, 8'h03, 16'hFFF0, 16'h0020}, 6, 1, -1);
        addFrame({8'h37, 8'h10, 16'h0000, 16'h0002, 8'h06, 32'h1111_2222}, 11, 1, -1);
        addFrame({8'h12, 8'h03, 16'h0000, 16'h0001}, 6, 0, -1); // foreign station
        addFrame({8'h37, 8'h03, 16'h0000, 16'h0001}, 6, 0, 2);
        addFrame({8'h37, 8'h04, 16'h0100, 16'h0001}, 6, 1, -1);
        addFrame({8'h37, 8'h03, 16'h0040, 16'h0008}, 6, 1, -1);
        tableReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue("txReq", txReq, 1'b0);
        checkValue("wbOut.cyc", wbOut.cyc, 1'b0);
        checkValue("wbOut.stb", wbOut.stb, 1'b0);
        checkValue("requestValid", u_modbusWishboneBridge.requestValid, 1'b0);
        for (int e = 0; e < numFrames; e++) begin
            runFrame(e);
        end
        pulseSilence();
        $display("Test OK");
        $finish;
    end

endmodule
